// File: sim.f
+incdir+source
source/sd_rx_pkg.sv
source/host_msg_pkg.sv
source/dat_in_fifo.sv
source/cmd6_block_tracker.sv
source/host_msg_engine.sv
source/sd_dat_in_top.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: Makefile
TOP := tb_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o Vtb_top
	@out="$$(./obj_dir/Vtb_top)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf obj_dir

// File: dv/tb_top.sv
`include "sd_rx_macros.svh"

module tb_top
    import sd_rx_pkg::*, host_msg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic        is_write;
        logic [7:0]  n_words;
        logic [7:0]  opcode;
        logic [55:0] arg;
        logic [7:0]  hold;      // Cycles of resp_ready low after accept
    } entry_s;

    logic       clk;
    logic       rst_;
    logic       dat_in_trigger;
    sd_word_t   dat_in_data;
    logic       dat_in_ready;
    logic       msg_valid;
    host_msg_s  msg;
    logic       msg_ready;
    logic       resp_valid;
    host_resp_s resp;
    logic       resp_ready;
    logic [3:0] led;

    logic       exp_push;
    host_resp_s exp_resp;
    logic [3:0] exp_led;
    logic       ready_chk;
    logic       exp_ready;
    logic       run_done;
    int         check_count;
    int         err_count;
    int         hs_errs;

    // Reference model of the data path
    entry_s      stim_q [$];
    sd_word_t    pending [$];   // Waiting to be offered
    sd_word_t    model_q [$];   // Accepted and not yet read out
    int          total_acc;
    logic [3:0]  m_mode;
    logic        m_mode_valid;
    logic [31:0] rng;
    logic        ready_s;

    sd_dat_in_top dut0 (
        .sd_datInWrite_clk  (clk),
        .sd_datInWrite_rst_ (rst_),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .dat_in_ready       (dat_in_ready),
        .msg_valid          (msg_valid),
        .msg                (msg),
        .msg_ready          (msg_ready),
        .resp_valid         (resp_valid),
        .resp               (resp),
        .resp_ready         (resp_ready),
        .led                (led)
    );

    tb_checker chk0 (
        .sd_datInWrite_clk  (clk),
        .sd_datInWrite_rst_ (rst_),
        .resp_valid         (resp_valid),
        .resp               (resp),
        .resp_ready         (resp_ready),
        .msg_ready          (msg_ready),
        .led                (led),
        .dat_in_ready       (dat_in_ready),
        .exp_push           (exp_push),
        .exp_resp           (exp_resp),
        .exp_led            (exp_led),
        .ready_chk          (ready_chk),
        .exp_ready          (exp_ready),
        .run_done           (run_done),
        .check_count        (check_count),
        .err_count          (err_count)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_write(input int n);
        stim_q.push_back('{1'b1, 8'(n), 8'h00, 56'd0, 8'd0});
    endtask

    task automatic add_msg(input logic [7:0] op, input logic [55:0] arg, input int hold);
        stim_q.push_back('{1'b0, 8'd0, op, arg, 8'(hold)});
    endtask

    // Block position follows the accept count
    task automatic record_word(input sd_word_t w);
        model_q.push_back(w);
        if (total_acc % `SD_BLOCK_WORDS == `CMD6_MODE_WORD) begin
            m_mode       = w[11:8];
            m_mode_valid = 1'b1;
        end
        total_acc++;
    endtask

    // ===============================================
    // SD word source that holds its word while not ready
    // ===============================================
    always @(negedge clk) ready_s = dat_in_ready;

    always @(posedge clk or negedge rst_) begin
        if (!rst_) begin
            dat_in_trigger <= 1'b0;
            dat_in_data    <= '0;
        end else begin
            if (dat_in_trigger && ready_s) begin
                record_word(pending[0]);
                void'(pending.pop_front());
            end
            if (pending.size() > 0) begin
                dat_in_trigger <= 1'b1;
                dat_in_data    <= pending[0];
            end else begin
                dat_in_trigger <= 1'b0;
            end
        end
    end

    task automatic write_words(input int n);
        @(negedge clk);
        repeat (n) begin
            rng = xorshift32(rng);
            pending.push_back(rng[15:0]);
        end
    endtask

    // No word can land while a message is accepted
    task automatic wait_quiet();
        int calm;
        calm = 0;
        while (calm < 4) begin
            @(negedge clk);
            if (pending.size() == 0 || !dat_in_ready) calm++;
            else calm = 0;
        end
    endtask

    task automatic send_msg(input entry_s e);
        host_resp_s expv;
        logic       want;
        logic       rdy;
        int         k;
        int         tmo;
        wait_quiet();
        @(posedge clk);
        msg_valid <= 1'b1;
        msg       <= '{opcode: e.opcode, arg: e.arg};
        if (e.hold != 0) resp_ready <= 1'b0;
        tmo = 0;
        rdy = 1'b0;
        while (!rdy && tmo < 200) begin
            @(negedge clk);
            rdy = msg_ready;
            @(posedge clk);
            tmo++;
        end
        msg_valid <= 1'b0;
        if (!rdy) begin
            $display("Message with opcode %h was never accepted", e.opcode);
            hs_errs++;
            resp_ready <= 1'b1;
            return;
        end

        // FIFO is full only when the model holds a whole FIFO of words
        exp_ready <= (model_q.size() < `FIFO_DEPTH);
        ready_chk <= 1'b1;

        // Expected reply from the reference model
        want         = 1'b1;
        expv.opcode  = e.opcode;
        expv.payload = '0;
        case (e.opcode)
            ECHO:      expv.payload = e.arg;
            SD_STATUS: expv.payload = {8'(total_acc / `SD_BLOCK_WORDS), m_mode, m_mode_valid,
                                       5'(model_q.size()), 38'd0};
            SD_READOUT: begin
                k = (model_q.size() < `READOUT_MAX) ? model_q.size() : `READOUT_MAX;
                for (int i = 0; i < k; i++) begin
                    expv.payload[55 - 16 * i -: 16] = model_q.pop_front();
                end
                expv.payload[7:0] = 8'(k);
            end
            LED_SET: begin
                exp_led <= e.arg[3:0];
                want = 1'b0;
            end
            NOP:     want = 1'b0;
            default: expv.opcode = `RESP_ERR_OP;
        endcase
        if (want) begin
            exp_resp <= expv;
            exp_push <= 1'b1;
        end
        @(posedge clk);
        exp_push  <= 1'b0;
        ready_chk <= 1'b0;
        if (e.hold != 0) begin
            repeat (e.hold) @(posedge clk);
            resp_ready <= 1'b1;
        end
        if (want) begin
            tmo = 0;
            rdy = 1'b0;
            while (!rdy && tmo < 100) begin     // Bounded wait for the reply
                @(negedge clk);
                rdy = resp_valid && resp_ready;
                tmo++;
            end
            @(posedge clk);
        end else begin
            repeat (3) @(posedge clk);
        end
    endtask

    // ===============================================
    // Main sequence
    // ===============================================
    initial begin
        clk            = 1'b0;
        rst_           = 1'b0;
        dat_in_trigger = 1'b0;
        dat_in_data    = '0;
        msg_valid      = 1'b0;
        msg            = '0;
        resp_ready     = 1'b1;
        exp_push       = 1'b0;
        exp_resp       = '0;
        exp_led        = '0;
        ready_chk      = 1'b0;
        exp_ready      = 1'b1;
        run_done       = 1'b0;
        hs_errs        = 0;
        total_acc      = 0;
        m_mode         = '0;
        m_mode_valid   = 1'b0;
        rng            = 32'd6;
        ready_s        = 1'b0;

        add_msg(ECHO, 56'h01_2345_6789_ABCD, 0);
        add_msg(LED_SET, 56'h5, 0);
        add_msg(LED_SET, 56'hFA3, 0);
        add_write(12);
        add_msg(SD_STATUS, 56'd0, 0);
        repeat (3) add_msg(SD_READOUT, 56'd0, 0);
        add_write(20);                          // Overfills the FIFO
        add_msg(SD_STATUS, 56'd0, 0);
        add_msg(SD_READOUT, 56'd0, 10);         // Reply held off
        repeat (2) add_msg(SD_READOUT, 56'd0, 0);
        add_msg(SD_STATUS, 56'd0, 0);           // One full block by now
        repeat (5) add_msg(SD_READOUT, 56'd0, 0);
        add_msg(SD_READOUT, 56'd0, 0);          // Empty FIFO
        add_msg(SD_STATUS, 56'd0, 0);
        add_msg(8'h55, 56'h77, 0);
        add_msg(NOP, 56'h1234, 0);
        add_msg(ECHO, 56'hDE_ADBE_EF00_1122, 6);
        add_msg(LED_SET, 56'hC, 0);
        add_msg(8'hC7, 56'd0, 3);

        fork
            begin
                #((stim_q.size() * 200 + 100) * 40);
                $display("Watchdog expired before the test sequence finished");
                $display("Test failures found");
                $finish;
            end
        join_none

        repeat (3) @(posedge clk);
        rst_ <= 1'b1;
        @(posedge clk);

        foreach (stim_q[i]) begin
            if (stim_q[i].is_write) write_words(int'(stim_q[i].n_words));
            else send_msg(stim_q[i]);
        end

        repeat (5) @(posedge clk);
        run_done <= 1'b1;
        repeat (2) @(negedge clk);
        $display("Checks: %0d  Errors: %0d", check_count, err_count + hs_errs);
        if (err_count + hs_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: dv/tb_checker.sv
module tb_checker
    import host_msg_pkg::*;
(
    input  logic       sd_datInWrite_clk,
    input  logic       sd_datInWrite_rst_,
    input  logic       resp_valid,
    input  host_resp_s resp,
    input  logic       resp_ready,
    input  logic       msg_ready,
    input  logic [3:0] led,
    input  logic       dat_in_ready,
    input  logic       exp_push,
    input  host_resp_s exp_resp,
    input  logic [3:0] exp_led,
    input  logic       ready_chk,
    input  logic       exp_ready,
    input  logic       run_done,
    output int         check_count,
    output int         err_count
);
    timeunit 1ns;
    timeprecision 100ps;

    host_resp_s exp_q [$];
    host_resp_s prev_resp;
    host_resp_s want;
    logic       held = 1'b0;        // Previous cycle had valid without ready
    logic       flagged = 1'b0;     // Current unexpected reply already reported
    logic       reported = 1'b0;

    initial begin
        check_count = 0;
        err_count   = 0;
    end

    // ===============================================
    // Sampled on the falling edge
    // ===============================================
    always @(negedge sd_datInWrite_clk) begin
        if (sd_datInWrite_rst_) begin
            if (exp_push) begin
                exp_q.push_back(exp_resp);
            end

            check_count++;
            if (led !== exp_led) begin
                $display("MISMATCH led: got %h expected %h", led, exp_led);
                err_count++;
            end

            // Full flag at the moment a message is taken
            if (ready_chk) begin
                check_count++;
                if (dat_in_ready !== exp_ready) begin
                    $display("MISMATCH dat_in_ready: got %h expected %h",
                             dat_in_ready, exp_ready);
                    err_count++;
                end
            end

            if (resp_valid) begin
                if (held) begin     // Back-pressure window
                    check_count++;
                    if (resp !== prev_resp) begin
                        $display("MISMATCH resp (hold): got %h expected %h", resp, prev_resp);
                        err_count++;
                    end
                    if (msg_ready) begin
                        $display("msg_ready went high while a response was waiting");
                        err_count++;
                    end
                end
                if (exp_q.size() == 0 && !flagged) begin
                    $display("A response %h arrived when none was expected", resp);
                    err_count++;
                    flagged = 1'b1;
                end
                if (resp_ready) begin
                    if (exp_q.size() > 0) begin
                        want = exp_q.pop_front();
                        check_count++;
                        if (resp !== want) begin
                            $display("MISMATCH resp: got %h expected %h", resp, want);
                            err_count++;
                        end
                    end
                    flagged = 1'b0;
                end
                held      = !resp_ready;
                prev_resp = resp;
            end else begin
                held = 1'b0;
            end

            // Anything still queued at the end never showed up
            if (run_done && !reported) begin
                if (exp_q.size() > 0) begin
                    $display("%0d expected responses never arrived", exp_q.size());
                    err_count += exp_q.size();
                end
                reported = 1'b1;
            end
        end
    end

endmodule

// File: source/sd_dat_in_top.sv
module sd_dat_in_top
    import sd_rx_pkg::*, host_msg_pkg::*;
(
    input  logic       sd_datInWrite_clk,
    input  logic       sd_datInWrite_rst_,

    // SD data-in port
    input  logic       dat_in_trigger,
    input  sd_word_t   dat_in_data,
    output logic       dat_in_ready,

    // Host message port
    input  logic       msg_valid,
    input  host_msg_s  msg,
    output logic       msg_ready,

    // Host response port
    output logic       resp_valid,
    output host_resp_s resp,
    input  logic       resp_ready,

    output logic [3:0] led
);

    dat_in_word_s  accepted;
    block_status_s status;
    logic          pop;
    sd_word_t      head;
    fifo_level_t   level;

    // ===============================================
    // Word buffer
    // ===============================================
    dat_in_fifo u_fifo (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .dat_in_trigger     (dat_in_trigger),
        .dat_in_data        (dat_in_data),
        .dat_in_ready       (dat_in_ready),
        .accepted           (accepted),
        .pop                (pop),
        .head               (head),
        .level              (level)
    );

    // Runs beside the FIFO on the same accepted words
    cmd6_block_tracker u_tracker (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .accepted           (accepted),
        .status             (status)
    );

    // ===============================================
    // Host side
    // ===============================================
    host_msg_engine u_engine (
        .sd_datInWrite_clk  (sd_datInWrite_clk),
        .sd_datInWrite_rst_ (sd_datInWrite_rst_),
        .msg_valid          (msg_valid),
        .msg                (msg),
        .msg_ready          (msg_ready),
        .resp_valid         (resp_valid),
        .resp               (resp),
        .resp_ready         (resp_ready),
        .led                (led),
        .status             (status),
        .head               (head),
        .level              (level),
        .pop                (pop)
    );

endmodule

// File: source/host_msg_engine.sv
`include "sd_rx_macros.svh"

module host_msg_engine
    import sd_rx_pkg::*, host_msg_pkg::*;
(
    input  logic          sd_datInWrite_clk,
    input  logic          sd_datInWrite_rst_,
    input  logic          msg_valid,
    input  host_msg_s     msg,
    output logic          msg_ready,
    output logic          resp_valid,
    output host_resp_s    resp,
    input  logic          resp_ready,
    output logic [3:0]    led,
    input  block_status_s status,
    input  sd_word_t      head,
    input  fifo_level_t   level,
    output logic          pop
);

    localparam int CNT_W    = $clog2(`READOUT_MAX + 1);
    localparam int SLOT_MSB = 55;   // Top bit of the first readout slot

    engine_state_e    state;
    msg_type_e        op;
    logic             accept;
    logic [CNT_W-1:0] avail;        // Words this readout will take
    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] rd_target;
    host_resp_s       resp_q;

    assign op         = msg_type_e'(msg.opcode);
    assign msg_ready  = (state == IDLE);
    assign accept     = msg_valid && msg_ready;
    assign resp_valid = (state == RESP);
    assign resp       = resp_q;

    assign avail = (level > fifo_level_t'(`READOUT_MAX)) ? CNT_W'(`READOUT_MAX)
                                                         : CNT_W'(level);

    // One word per cycle until the target is reached
    assign pop = (state == POP) && (rd_cnt != rd_target);

    // ===============================================
    // FSM, LED register and readout counter
    // ===============================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state     <= IDLE;
            led       <= '0;
            rd_cnt    <= '0;
            rd_target <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        case (op)
                            NOP: begin
                                // Nothing to do, no reply
                            end
                            LED_SET: led <= msg.arg[3:0];
                            SD_READOUT: begin
                                rd_cnt    <= '0;
                                rd_target <= avail;     // Snapshot of level at accept
                                state     <= POP;
                            end
                            default: state <= RESP;     // Echo, status and bad opcodes
                        endcase
                    end
                end

                POP: begin
                    if (pop) begin
                        rd_cnt <= rd_cnt + 1'b1;
                    end else begin
                        state <= RESP;
                    end
                end

                RESP: begin
                    if (resp_ready) begin
                        state <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // ===============================================
    // Response word
    // ===============================================
    // Only written on accept and during POP, so it holds through RESP
    always_ff @(posedge sd_datInWrite_clk) begin
        if (accept) begin
            resp_q.opcode  <= msg.opcode;
            resp_q.payload <= '0;
            case (op)
                ECHO:      resp_q.payload <= msg.arg;
                SD_STATUS: resp_q.payload <= {status.block_count, status.access_mode,
                                              status.mode_valid, level, 38'd0};
                NOP, LED_SET, SD_READOUT: begin
                    // Payload filled later or never sent
                end
                default:   resp_q.opcode <= `RESP_ERR_OP;
            endcase
        end else if (pop) begin
            resp_q.payload[SLOT_MSB - `SD_WORD_W * int'(rd_cnt) -: `SD_WORD_W] <= head;
        end else if (state == POP) begin
            resp_q.payload[7:0] <= 8'(rd_cnt);     // Word count on the way out
        end
    end

    // Host sees a frozen reply until it takes it
    a_resp_hold: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp));

endmodule

// File: source/cmd6_block_tracker.sv
`include "sd_rx_macros.svh"

module cmd6_block_tracker
    import sd_rx_pkg::*;
(
    input  logic          sd_datInWrite_clk,
    input  logic          sd_datInWrite_rst_,
    input  dat_in_word_s  accepted,
    output block_status_s status
);

    localparam int IDX_W = $clog2(`SD_BLOCK_WORDS);

    logic [IDX_W-1:0] word_idx;     // Position inside the current block
    logic             last_word;
    logic             mode_word;

    assign last_word = (word_idx == IDX_W'(`SD_BLOCK_WORDS - 1));
    assign mode_word = (word_idx == IDX_W'(`CMD6_MODE_WORD));

    // ===============================================
    // Word index, block count and CMD6 capture
    // ===============================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_idx <= '0;
            status   <= '0;
        end else if (accepted.valid) begin
            if (last_word) begin
                word_idx           <= '0;
                status.block_count <= status.block_count + 1'b1;   // Wraps at 256
            end else begin
                word_idx <= word_idx + 1'b1;
            end

            // Mode field sits in the ninth word of the switch status
            if (mode_word) begin
                status.access_mode <= accepted.data[`CMD6_MODE_LSB +: 4];
                status.mode_valid  <= 1'b1;
            end
        end
    end

    a_idx_bound: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        word_idx < IDX_W'(`SD_BLOCK_WORDS - 1) || last_word);

endmodule

// File: source/dat_in_fifo.sv
`include "sd_rx_macros.svh"

module dat_in_fifo
    import sd_rx_pkg::*;
(
    input  logic         sd_datInWrite_clk,
    input  logic         sd_datInWrite_rst_,
    input  logic         dat_in_trigger,
    input  sd_word_t     dat_in_data,
    output logic         dat_in_ready,
    output dat_in_word_s accepted,
    input  logic         pop,
    output sd_word_t     head,
    output fifo_level_t  level
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    sd_word_t         mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             full;
    logic             push;
    logic             do_pop;
    logic             acc_valid;
    sd_word_t         acc_data;

    assign full         = (level == fifo_level_t'(`FIFO_DEPTH));
    assign dat_in_ready = !full;
    assign push         = dat_in_trigger && dat_in_ready;   // Trigger/ready handshake
    assign do_pop       = pop && (level != '0);
    assign head         = mem[rd_ptr];

    // Strobe for the tracker, one cycle behind the handshake
    assign accepted = '{data: acc_data, valid: acc_valid};

    // ===============================================
    // Storage
    // ===============================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (push) begin
            mem[wr_ptr] <= dat_in_data;
        end
        acc_data <= dat_in_data;
    end

    // ===============================================
    // Pointers and fill level
    // ===============================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= push;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;    // Both or neither
            endcase
        end
    end

    // Engine only pops words it has seen in level
    a_no_pop_empty: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        pop |-> level != '0);

    a_level_bound: assert property (@(posedge sd_datInWrite_clk) disable iff (!sd_datInWrite_rst_)
        level <= fifo_level_t'(`FIFO_DEPTH));

endmodule

// File: source/host_msg_pkg.sv
package host_msg_pkg;

    // ===============================================
    // Message opcodes
    // ===============================================
    // Bit 7 set means the host expects a reply
    typedef enum logic [7:0] {
        NOP        = 8'h00,
        LED_SET    = 8'h02,
        ECHO       = 8'h81,
        SD_STATUS  = 8'h83,
        SD_READOUT = 8'h84
    } msg_type_e;

    // ===============================================
    // Message and response words
    // ===============================================
    // Opcode kept as raw bits so unknown values pass through intact
    typedef struct packed {
        logic [7:0]  opcode;
        logic [55:0] arg;
    } host_msg_s;

    // SD_STATUS payload map
    //   55:48 block count
    //   47:44 access mode
    //   43    mode valid
    //   42:38 FIFO level
    // SD_READOUT payload map
    //   55:40 first word, 39:24 second, 23:8 third
    //   7:0   number of words popped
    typedef struct packed {
        logic [7:0]  opcode;    // Echo of the message opcode
        logic [55:0] payload;
    } host_resp_s;

    // Engine FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // Waiting for a message
        POP  = 2'd1,    // Draining words for a readout
        RESP = 2'd2     // Holding a reply for the host
    } engine_state_e;

endpackage

// File: source/sd_rx_pkg.sv
`include "sd_rx_macros.svh"

package sd_rx_pkg;

    // One data word as written by the SD side
    typedef logic [`SD_WORD_W-1:0] sd_word_t;

    // Fill level, needs one bit more than the pointers
    typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] fifo_level_t;

    // ===============================================
    // Accepted-word strobe, FIFO to tracker
    // ===============================================
    typedef struct packed {
        sd_word_t data;
        logic     valid;        // One cycle per accepted word
    } dat_in_word_s;

    // ===============================================
    // Block tracker state seen by the host side
    // ===============================================
    typedef struct packed {
        logic [7:0] block_count;    // Full blocks seen, wraps
        logic [3:0] access_mode;    // Last captured CMD6 mode
        logic       mode_valid;     // Set once a mode word went by
    } block_status_s;

endpackage

// File: source/sd_rx_macros.svh
`ifndef SD_RX_MACROS_SVH
`define SD_RX_MACROS_SVH

// ===============================================
// SD data word and block geometry
// ===============================================
`define SD_WORD_W       16      // One word off the DAT lines
`define SD_BLOCK_WORDS  32      // 512-bit block

// CMD6 switch status carries the access mode in one word of the block
`define CMD6_MODE_WORD  8
`define CMD6_MODE_LSB   8       // Low bit of the 4-bit mode field

// ===============================================
// Buffering and host readout
// ===============================================
`define FIFO_DEPTH      16      // Power of two, pointers wrap freely
`define READOUT_MAX     3       // Words per SD_READOUT reply

// Opcode field of the reply to an unknown message
`define RESP_ERR_OP     8'hEE

`endif
